//--- ising_cfg.f
+incdir+logic
logic/ising_cfg_pkg.sv
logic/ising_data_pkg.sv
logic/cfg_if.sv
logic/step_counter.sv
logic/cfg_regfile.sv
logic/weight_buffer.sv
logic/analog_cfg.sv
logic/wbl_encoder.sv
logic/ising_cfg_top.sv
verif/tb_ising_cfg.sv

//--- logic/analog_cfg.sv
// Analog array programming sequencer
// Walks the J words slice by slice, then the H row, strobing each row
// to the bit-line encoder and pulsing its write wordline.
// Per row: fetch, load, high for wwl_high+1 cycles, low for wwl_low+1

`default_nettype none

`include "ising_cfg_consts.svh"

module analog_cfg
    import ising_cfg_pkg::*;
    import ising_data_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       en_i,
    input  logic                       cfg_configure_enable_i,
    input  logic                       dt_cfg_enable_i,
    cfg_if.seq                         cfg,
    output logic                       j_ren_o,
    output jaddr_t                     j_raddr_o,
    input  jword_t                     j_rdata_i,
    output logic                       h_ren_o,
    input  row_t                       h_rdata_i,
    output row_t                       row_o,
    output logic                       row_load_o,
    output logic [`ISING_NUM_SPIN-1:0] j_one_hot_wwl_o,
    output logic                       h_wwl_o,
    output logic                       dt_cfg_idle_o
);

    localparam int NUM_SPIN    = `ISING_NUM_SPIN;
    localparam int PARALLELISM = `ISING_PARALLELISM;

    logic                busy_q;
    phase_t              phase_q;
    sel_t                sel_q;
    logic                cfg_load_q;
    logic [NUM_SPIN-1:0] j_wwl_q;
    logic                h_wwl_q;

    cnt_t                addr_q;
    cnt_t                spin_idx;
    logic [NUM_SPIN-1:0] wwl_next;
    logic                start;
    logic                h_phase;
    logic                sel_last;
    logic                high_done;
    logic                low_done;
    logic                addr_step;
    logic                sweep_done;

    assign start    = en_i & dt_cfg_enable_i & ~busy_q;
    assign sel_last = (sel_q == sel_t'(PARALLELISM - 1));

    // Next word after the last slice, end of sweep after H
    assign addr_step = busy_q & low_done & (h_phase | sel_last);

    assign spin_idx = addr_q * cnt_t'(PARALLELISM) + cnt_t'(sel_q);
    assign wwl_next = {{(NUM_SPIN-1){1'b0}}, 1'b1} << spin_idx;

    assign j_ren_o   = busy_q & (phase_q == PH_READ) & ~h_phase;
    assign h_ren_o   = busy_q & (phase_q == PH_READ) & h_phase;
    assign j_raddr_o = jaddr_t'(addr_q);

    assign row_o      = h_phase ? h_rdata_i : j_rdata_i[sel_q];
    assign row_load_o = busy_q & (phase_q == PH_LOAD);

    // Regfile outputs settle one cycle after the configure strobe
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cfg_load_q <= 1'b0;
        end else begin
            cfg_load_q <= cfg_configure_enable_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q  <= 1'b0;
            phase_q <= PH_READ;
        end else if (!en_i) begin
            busy_q  <= 1'b0;
            phase_q <= PH_READ;
        end else if (start) begin
            busy_q  <= 1'b1;
            phase_q <= PH_READ;
        end else if (busy_q) begin
            unique case (phase_q)
                PH_READ: phase_q <= PH_LOAD;
                PH_LOAD: phase_q <= PH_HIGH;
                PH_HIGH: begin
                    if (high_done) begin
                        phase_q <= PH_LOW;
                    end
                end
                PH_LOW: begin
                    if (sweep_done) begin
                        busy_q  <= 1'b0;
                        phase_q <= PH_READ;
                    end else if (low_done) begin
                        // Remaining slices come from the word already read
                        phase_q <= sel_last ? PH_READ : PH_LOAD;
                    end
                end
                default: phase_q <= PH_READ;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sel_q <= '0;
        end else if (!en_i || start) begin
            sel_q <= '0;
        end else if (busy_q && low_done && !h_phase) begin
            sel_q <= sel_last ? '0 : sel_q + 1'b1;
        end
    end

    // Wordline rises on the same edge the encoder registers its row
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            j_wwl_q <= '0;
            h_wwl_q <= 1'b0;
        end else if (!en_i || high_done) begin
            j_wwl_q <= '0;
            h_wwl_q <= 1'b0;
        end else if (row_load_o) begin
            if (h_phase) begin
                h_wwl_q <= 1'b1;
            end else begin
                j_wwl_q <= wwl_next;
            end
        end
    end

    assign j_one_hot_wwl_o = j_wwl_q;
    assign h_wwl_o         = h_wwl_q;
    assign dt_cfg_idle_o   = ~busy_q;

    step_counter i_wwl_high_counter (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .en_i       (en_i),
        .load_i     (cfg_load_q),
        .d_i        (cfg.wwl_high),
        .recount_i  (start),
        .step_i     (busy_q & (phase_q == PH_HIGH)),
        .q_o        (),
        .maxed_o    (),
        .overflow_o (high_done)
    );

    step_counter i_wwl_low_counter (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .en_i       (en_i),
        .load_i     (cfg_load_q),
        .d_i        (cfg.wwl_low),
        .recount_i  (start),
        .step_i     (busy_q & (phase_q == PH_LOW)),
        .q_o        (),
        .maxed_o    (),
        .overflow_o (low_done)
    );

    // Count at trans_num selects the H row, wrapping past it ends the sweep
    step_counter i_addr_counter (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .en_i       (en_i),
        .load_i     (cfg_load_q),
        .d_i        (cfg.trans_num),
        .recount_i  (start),
        .step_i     (addr_step),
        .q_o        (addr_q),
        .maxed_o    (h_phase),
        .overflow_o (sweep_done)
    );

endmodule

`default_nettype wire

//--- logic/cfg_if.sv
// Configuration bundle
// Latched wordline timing, transfer count and conversion mode

`default_nettype none

interface cfg_if import ising_cfg_pkg::*; ();

    cnt_t wwl_high;
    cnt_t wwl_low;
    cnt_t trans_num;
    logic bypass;

    modport src (output wwl_high, output wwl_low, output trans_num, output bypass);

    modport seq (input wwl_high, input wwl_low, input trans_num);

    modport enc (input bypass);

endinterface

`default_nettype wire

//--- logic/cfg_regfile.sv
// Configuration register file
// Captures wordline timing, transfer count and bypass mode on the
// configure strobe and holds them for the sequencer and encoder

`default_nettype none

module cfg_regfile import ising_cfg_pkg::*; (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic cfg_configure_enable_i,
    input  cnt_t cycle_per_wwl_high_i,
    input  cnt_t cycle_per_wwl_low_i,
    input  cnt_t cfg_trans_num_i,
    input  logic bypass_data_conversion_i,
    cfg_if.src   cfg
);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cfg.wwl_high  <= '0;
            cfg.wwl_low   <= '0;
            cfg.trans_num <= '0;
            cfg.bypass    <= 1'b0;
        end else if (cfg_configure_enable_i) begin
            cfg.wwl_high  <= cycle_per_wwl_high_i;
            cfg.wwl_low   <= cycle_per_wwl_low_i;
            // Number of J words; the address after the last one selects H
            cfg.trans_num <= cfg_trans_num_i;
            cfg.bypass    <= bypass_data_conversion_i;
        end
    end

endmodule

`default_nettype wire

//--- logic/ising_cfg_consts.svh
// Ising array programming constants
// Array size, weight width, J word packing and counter width

`ifndef ISING_CFG_CONSTS_SVH
`define ISING_CFG_CONSTS_SVH

// Spins in the array, one J row and one write wordline each
`define ISING_NUM_SPIN 16

// Signed weight width
`define ISING_BITDATA 4

// Spin rows packed into one J buffer word
`define ISING_PARALLELISM 4

// Timing and address counters
`define ISING_CNT_W 16

`define ISING_J_DEPTH (`ISING_NUM_SPIN / `ISING_PARALLELISM)

`endif

//--- logic/ising_cfg_pkg.sv
// Ising configuration package
// Counter, sequencer phase and slice-select types

`default_nettype none

`include "ising_cfg_consts.svh"

package ising_cfg_pkg;

    // Timing limits, transfer count and counter values
    typedef logic [`ISING_CNT_W-1:0] cnt_t;

    // Row index inside one J buffer word
    typedef logic [(`ISING_PARALLELISM > 1 ? $clog2(`ISING_PARALLELISM) : 1)-1:0] sel_t;

    // Sequencer phase while a sweep runs
    typedef enum logic [1:0] {
        PH_READ,
        PH_LOAD,
        PH_HIGH,
        PH_LOW
    } phase_t;

endpackage

`default_nettype wire

//--- logic/ising_cfg_top.sv
// Ising array programming top level
// Host-written J and H buffers, configuration registers, the sweep
// sequencer and the bit-line encoder

`default_nettype none

`include "ising_cfg_consts.svh"

module ising_cfg_top
    import ising_cfg_pkg::*;
    import ising_data_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       en_i,
    input  logic                       cfg_configure_enable_i,
    input  cnt_t                       cycle_per_wwl_high_i,
    input  cnt_t                       cycle_per_wwl_low_i,
    input  cnt_t                       cfg_trans_num_i,
    input  logic                       bypass_data_conversion_i,
    input  logic                       j_we_i,
    input  jaddr_t                     j_waddr_i,
    input  jword_t                     j_wdata_i,
    input  logic                       h_we_i,
    input  row_t                       h_wdata_i,
    input  logic                       dt_cfg_enable_i,
    output logic [`ISING_NUM_SPIN-1:0] j_one_hot_wwl_o,
    output logic                       h_wwl_o,
    output row_t                       wbl_o,
    output logic                       dt_cfg_idle_o
);

    logic   j_ren;
    jaddr_t j_raddr;
    jword_t j_rdata;
    logic   h_ren;
    row_t   h_rdata;
    row_t   row;
    logic   row_load;

    cfg_if i_cfg_if ();

    cfg_regfile i_cfg_regfile (
        .clk_i                    (clk_i),
        .rst_n_i                  (rst_n_i),
        .cfg_configure_enable_i   (cfg_configure_enable_i),
        .cycle_per_wwl_high_i     (cycle_per_wwl_high_i),
        .cycle_per_wwl_low_i      (cycle_per_wwl_low_i),
        .cfg_trans_num_i          (cfg_trans_num_i),
        .bypass_data_conversion_i (bypass_data_conversion_i),
        .cfg                      (i_cfg_if.src)
    );

    weight_buffer #(
        .row_type (jword_t),
        .DEPTH    (`ISING_J_DEPTH)
    ) i_j_buffer (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .we_i    (j_we_i),
        .waddr_i (j_waddr_i),
        .wdata_i (j_wdata_i),
        .ren_i   (j_ren),
        .raddr_i (j_raddr),
        .rdata_o (j_rdata)
    );

    weight_buffer #(
        .row_type (row_t),
        .DEPTH    (1)
    ) i_h_buffer (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .we_i    (h_we_i),
        .waddr_i (1'b0),
        .wdata_i (h_wdata_i),
        .ren_i   (h_ren),
        .raddr_i (1'b0),
        .rdata_o (h_rdata)
    );

    analog_cfg i_analog_cfg (
        .clk_i                  (clk_i),
        .rst_n_i                (rst_n_i),
        .en_i                   (en_i),
        .cfg_configure_enable_i (cfg_configure_enable_i),
        .dt_cfg_enable_i        (dt_cfg_enable_i),
        .cfg                    (i_cfg_if.seq),
        .j_ren_o                (j_ren),
        .j_raddr_o              (j_raddr),
        .j_rdata_i              (j_rdata),
        .h_ren_o                (h_ren),
        .h_rdata_i              (h_rdata),
        .row_o                  (row),
        .row_load_o             (row_load),
        .j_one_hot_wwl_o        (j_one_hot_wwl_o),
        .h_wwl_o                (h_wwl_o),
        .dt_cfg_idle_o          (dt_cfg_idle_o)
    );

    wbl_encoder i_wbl_encoder (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .en_i    (en_i),
        .cfg     (i_cfg_if.enc),
        .row_i   (row),
        .load_i  (row_load),
        .wbl_o   (wbl_o)
    );

endmodule

`default_nettype wire

//--- logic/ising_data_pkg.sv
// Ising data package
// Weight, spin row, J buffer word and J address types

`default_nettype none

`include "ising_cfg_consts.svh"

package ising_data_pkg;

    // Two's-complement coupling weight
    typedef logic signed [`ISING_BITDATA-1:0] weight_t;

    // One weight per spin, spin 0 in the lowest bits
    typedef weight_t [`ISING_NUM_SPIN-1:0] row_t;

    // Row k of word a belongs to spin a*PARALLELISM+k
    typedef row_t [`ISING_PARALLELISM-1:0] jword_t;

    typedef logic [(`ISING_J_DEPTH > 1 ? $clog2(`ISING_J_DEPTH) : 1)-1:0] jaddr_t;

endpackage

`default_nettype wire

//--- logic/step_counter.sv
// Step counter
// Counts enabled steps up to a loaded limit and wraps to zero.
// maxed_o marks the limit, overflow_o the step that wraps.

`default_nettype none

module step_counter import ising_cfg_pkg::*; (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic en_i,
    input  logic load_i,
    input  cnt_t d_i,
    input  logic recount_i,
    input  logic step_i,
    output cnt_t q_o,
    output logic maxed_o,
    output logic overflow_o
);

    cnt_t limit_q;
    cnt_t count_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            limit_q <= '0;
        end else if (load_i) begin
            limit_q <= d_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else if (!en_i || recount_i || overflow_o) begin
            count_q <= '0;
        end else if (step_i) begin
            count_q <= count_q + 1'b1;
        end
    end

    assign q_o     = count_q;
    assign maxed_o = (count_q == limit_q);

    // Limit reached and stepped once more
    assign overflow_o = en_i & step_i & maxed_o;

endmodule

`default_nettype wire

//--- logic/wbl_encoder.sv
// Bit-line encoder
// Converts a row of two's-complement weights to the analog macro code,
// or passes it raw in bypass mode, and registers it on the load strobe

`default_nettype none

`include "ising_cfg_consts.svh"

module wbl_encoder import ising_data_pkg::*; (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic en_i,
    cfg_if.enc   cfg,
    input  row_t row_i,
    input  logic load_i,
    output row_t wbl_o
);

    localparam int W = $bits(weight_t);

    row_t code;
    row_t wbl_q;

    // Magnitude shifted up, sign flag in bit 0: +v -> 2v+1, -v -> 2|v|.
    // The most negative weight has no magnitude code and lands on zero
    function automatic weight_t encode(weight_t v);
        weight_t mag;
        mag = v[W-1] ? -v : v;
        return {mag[W-2:0], ~v[W-1] & (v != '0)};
    endfunction

    always_comb begin
        for (int i = 0; i < `ISING_NUM_SPIN; i++) begin
            code[i] = cfg.bypass ? row_i[i] : encode(row_i[i]);
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wbl_q <= '0;
        end else if (en_i && load_i) begin
            wbl_q <= code;
        end
    end

    assign wbl_o = wbl_q;

endmodule

`default_nettype wire

//--- logic/weight_buffer.sv
// Weight buffer
// Register storage for one row type, written by the host and
// read back with one cycle of latency

`default_nettype none

module weight_buffer #(
    parameter type row_type = logic [7:0],
    parameter int  DEPTH    = 4,
    localparam int AW       = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic          clk_i,
    input  logic          rst_n_i,
    input  logic          we_i,
    input  logic [AW-1:0] waddr_i,
    input  row_type       wdata_i,
    input  logic          ren_i,
    input  logic [AW-1:0] raddr_i,
    output row_type       rdata_o
);

    row_type mem_q [DEPTH];
    row_type rdata_q;

    always_ff @(posedge clk_i) begin
        if (we_i && (int'(waddr_i) < DEPTH)) begin
            mem_q[waddr_i] <= wdata_i;
        end
    end

    // Read data holds until the next read enable
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rdata_q <= '0;
        end else if (ren_i) begin
            rdata_q <= mem_q[raddr_i];
        end
    end

    assign rdata_o = rdata_q;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the Ising programming testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module tb_ising_cfg \
    -f ising_cfg.f \
    -o tb_ising_cfg

./obj_dir/tb_ising_cfg | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation passed"

//--- verif/tb_ising_cfg.sv
// Ising array programming testbench
// Loads J and H weights, runs table-driven sweeps and checks the wordline
// order, bit-line codes and relative pulse timing against a reference model

`default_nettype none

`include "ising_cfg_consts.svh"

module tb_ising_cfg
    import ising_cfg_pkg::*;
    import ising_data_pkg::*;
();

    localparam int NUM_SPIN  = `ISING_NUM_SPIN;
    localparam int BITDATA   = `ISING_BITDATA;
    localparam int PAR       = `ISING_PARALLELISM;
    localparam int J_DEPTH   = `ISING_J_DEPTH;
    localparam int NUM_TESTS = 6;
    localparam int KIND_RAND = 0;
    localparam int KIND_EDGE = 1;

    // Test table
    string test_name [NUM_TESTS] = '{"rand_convert", "rand_bypass", "long_high",
                                     "long_low", "edge_convert", "edge_bypass"};
    int    high_lim  [NUM_TESTS] = '{2, 2, 5, 2, 0, 1};
    int    low_lim   [NUM_TESTS] = '{1, 1, 1, 4, 0, 2};
    logic  bypass_on [NUM_TESTS] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1};
    int    kind      [NUM_TESTS] = '{KIND_RAND, KIND_RAND, KIND_RAND, KIND_RAND,
                                     KIND_EDGE, KIND_EDGE};

    int edge_vals [6] = '{-8, -7, -1, 0, 1, 7};

    logic                clk;
    logic                rst_n;
    logic                en;
    logic                cfg_configure_enable;
    cnt_t                cycle_high;
    cnt_t                cycle_low;
    cnt_t                trans_num;
    logic                bypass;
    logic                j_we;
    jaddr_t              j_waddr;
    jword_t              j_wdata;
    logic                h_we;
    row_t                h_wdata;
    logic                dt_cfg_enable;
    logic [NUM_SPIN-1:0] j_wwl;
    logic                h_wwl;
    row_t                wbl;
    logic                idle;

    int          j_w [NUM_SPIN][NUM_SPIN];
    int          h_w [NUM_SPIN];
    int          high_len [NUM_TESTS];
    int          gap_len [NUM_TESTS];
    logic [31:0] lfsr_q = 32'h88f3;
    string       test_label;
    int          checks = 0;
    int          errors = 0;

    ising_cfg_top i_dut (
        .clk_i                    (clk),
        .rst_n_i                  (rst_n),
        .en_i                     (en),
        .cfg_configure_enable_i   (cfg_configure_enable),
        .cycle_per_wwl_high_i     (cycle_high),
        .cycle_per_wwl_low_i      (cycle_low),
        .cfg_trans_num_i          (trans_num),
        .bypass_data_conversion_i (bypass),
        .j_we_i                   (j_we),
        .j_waddr_i                (j_waddr),
        .j_wdata_i                (j_wdata),
        .h_we_i                   (h_we),
        .h_wdata_i                (h_wdata),
        .dt_cfg_enable_i          (dt_cfg_enable),
        .j_one_hot_wwl_o          (j_wwl),
        .h_wwl_o                  (h_wwl),
        .wbl_o                    (wbl),
        .dt_cfg_idle_o            (idle)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic compare(input string what, input logic [63:0] expected,
                           input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[FAIL] %s %s: expected %h, actual %h", test_label, what, expected, actual);
        end
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic int random_weight();
        int v;
        v = 0;
        for (int b = 0; b < BITDATA; b++) begin
            v = v | (int'(lfsr_q[0]) << b);
            lfsr_q = lfsr_step(lfsr_q);
        end
        if (v >= (1 << (BITDATA - 1))) begin
            v = v - (1 << BITDATA);
        end
        return v;
    endfunction

    // Zero and the most negative weight both give macro code 0
    function automatic weight_t macro_code(input int v);
        if (v == 0 || v == -(1 << (BITDATA - 1))) begin
            return '0;
        end else if (v > 0) begin
            return weight_t'(2 * v + 1);
        end
        return weight_t'(-2 * v);
    endfunction

    // Index NUM_SPIN stands for the H row
    function automatic row_t expected_row(input int idx, input logic raw);
        row_t r;
        int   w;
        for (int c = 0; c < NUM_SPIN; c++) begin
            w = (idx < NUM_SPIN) ? j_w[idx][c] : h_w[c];
            r[c] = raw ? weight_t'(w) : macro_code(w);
        end
        return r;
    endfunction

    function automatic int relation(input int a, input int b);
        if (a < b) begin
            return 1;
        end else if (a > b) begin
            return 2;
        end
        return 0;
    endfunction

    task automatic fill_weights(input int t);
        for (int r = 0; r < NUM_SPIN; r++) begin
            for (int c = 0; c < NUM_SPIN; c++) begin
                j_w[r][c] = (kind[t] == KIND_RAND) ? random_weight() : edge_vals[(r + c) % 6];
            end
        end
        for (int c = 0; c < NUM_SPIN; c++) begin
            h_w[c] = (kind[t] == KIND_RAND) ? random_weight() : edge_vals[c % 6];
        end
    endtask

    task automatic load_buffers();
        jword_t word;
        for (int a = 0; a < J_DEPTH; a++) begin
            for (int k = 0; k < PAR; k++) begin
                word[k] = expected_row(a * PAR + k, 1'b1);
            end
            @(posedge clk);
            j_we    <= 1'b1;
            j_waddr <= jaddr_t'(a);
            j_wdata <= word;
        end
        @(posedge clk);
        j_we    <= 1'b0;
        h_we    <= 1'b1;
        h_wdata <= expected_row(NUM_SPIN, 1'b1);
        @(posedge clk);
        h_we <= 1'b0;
    endtask

    task automatic configure(input int t);
        @(posedge clk);
        cfg_configure_enable <= 1'b1;
        cycle_high           <= cnt_t'(high_lim[t]);
        cycle_low            <= cnt_t'(low_lim[t]);
        trans_num            <= cnt_t'(J_DEPTH);
        bypass               <= bypass_on[t];
        @(posedge clk);
        cfg_configure_enable <= 1'b0;
        // Counters pick up the new limits a cycle after the registers
        repeat (2) @(posedge clk);
    endtask

    task automatic run_sweep(input int t);
        logic [NUM_SPIN:0] wl;
        logic [NUM_SPIN:0] exp_wl;
        logic              prev_active;
        logic              done;
        int                next_idx;
        int                cur;
        int                pulse_len;
        int                first_len;
        int                gap_total;
        prev_active = 1'b0;
        done        = 1'b0;
        next_idx    = 0;
        cur         = 0;
        pulse_len   = 0;
        first_len   = -1;
        gap_total   = 0;
        @(negedge clk);
        compare("idle before start", 64'(1'b1), 64'(idle));
        @(posedge clk);
        dt_cfg_enable <= 1'b1;
        @(posedge clk);
        dt_cfg_enable <= 1'b0;
        @(negedge clk);
        compare("idle after start", 64'(1'b0), 64'(idle));
        while (!done) begin
            wl = {h_wwl, j_wwl};
            if (wl != '0) begin
                if (!prev_active) begin
                    cur       = next_idx;
                    next_idx  = next_idx + 1;
                    pulse_len = 0;
                end
                pulse_len++;
                exp_wl = '0;
                if (cur <= NUM_SPIN) begin
                    exp_wl[cur] = 1'b1;
                end
                compare($sformatf("wordlines, pulse %0d", cur), 64'(exp_wl), 64'(wl));
                compare($sformatf("bit lines, row %0d", cur),
                        64'(expected_row(cur, bypass_on[t])), 64'(wbl));
                prev_active = 1'b1;
            end else begin
                if (prev_active) begin
                    if (first_len < 0) begin
                        first_len = pulse_len;
                    end else begin
                        compare($sformatf("high time, pulse %0d", cur), 64'(first_len),
                                64'(pulse_len));
                    end
                end
                if (next_idx > 0 && !idle) begin
                    gap_total++;
                end
                prev_active = 1'b0;
            end
            done = idle;
            if (!done) begin
                @(negedge clk);
            end
        end
        compare("pulse count", 64'(NUM_SPIN + 1), 64'(next_idx));
        compare("wordlines at idle", 64'(0), 64'({h_wwl, j_wwl}));
        high_len[t] = first_len;
        gap_len[t]  = gap_total;
    endtask

    // Bound is the summed sweep lengths plus room for writes and setup
    initial begin : watchdog
        int limit_cycles;
        limit_cycles = 50;
        for (int t = 0; t < NUM_TESTS; t++) begin
            limit_cycles += (NUM_SPIN + 1) * (high_lim[t] + low_lim[t] + 4) + 100;
        end
        repeat (limit_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, a sweep never returned to idle",
                 limit_cycles);
        $display("Test failed");
        $finish;
    end

    initial begin
        rst_n                = 1'b0;
        en                   = 1'b0;
        cfg_configure_enable = 1'b0;
        cycle_high           = '0;
        cycle_low            = '0;
        trans_num            = '0;
        bypass               = 1'b0;
        j_we                 = 1'b0;
        j_waddr              = '0;
        j_wdata              = '0;
        h_we                 = 1'b0;
        h_wdata              = '0;
        dt_cfg_enable        = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        en    <= 1'b1;
        test_label = "reset";
        @(negedge clk);
        compare("idle", 64'(1'b1), 64'(idle));
        compare("bit lines", 64'(0), 64'(wbl));
        compare("wordlines", 64'(0), 64'({h_wwl, j_wwl}));
        for (int t = 0; t < NUM_TESTS; t++) begin
            test_label = test_name[t];
            fill_weights(t);
            load_buffers();
            configure(t);
            run_sweep(t);
        end
        // Pulse and gap lengths follow the limits in relative order
        test_label = "timing";
        for (int i = 0; i < NUM_TESTS; i++) begin
            for (int j = i + 1; j < NUM_TESTS; j++) begin
                compare($sformatf("high order %0d/%0d", i, j),
                        64'(relation(high_lim[i], high_lim[j])),
                        64'(relation(high_len[i], high_len[j])));
                compare($sformatf("gap order %0d/%0d", i, j),
                        64'(relation(low_lim[i], low_lim[j])),
                        64'(relation(gap_len[i], gap_len[j])));
            end
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
